//--- sample_in_ball.f
source/sib_pkg.sv
source/sample_in_ball_ctrl.sv
source/sample_in_ball_shuffler.sv
source/sib_coeff_mem.sv
source/sib_top.sv
test/sib_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing
TOP        ?= sib_tb
FILELIST   ?= sample_in_ball.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- test/sib_testdata.txt
# B <beat>: 32-bit stream beat in hex, byte 0 in the low bits
# E <index> <sign>: nonzero coefficient, sign 0 is +1 and sign 1 is q-1
B F0F0F0F0
B 0000005A
B DB0505FF
B DEF0DCDA
B E0FDFEFF
B E2E1E0DF
B E6E5E4E3
B EAE9E8E7
B EEEDECEB
B F2F1F0EF
B F6F5F4F3
B FAF9F8F7
B FDFCFBFF
B FFFEFFFF
E 5 0
E 218 0
E 219 0
E 220 1
E 221 0
E 222 1
E 223 1
E 224 1
E 225 0
E 226 0
E 227 0
E 228 0
E 229 1
E 230 1
E 231 1
E 232 1
E 233 0
E 234 0
E 235 0
E 236 0
E 237 1
E 238 1
E 239 1
E 240 1
E 241 0
E 242 0
E 243 0
E 244 0
E 245 1
E 246 1
E 247 1
E 248 1
E 249 0
E 250 1
E 251 0
E 252 1
E 253 1
E 254 0
E 255 1

//--- test/sib_tb.sv
// ==========================================================
// SampleInBall testbench
// Streams file beats with random gaps, checks done, hold,
// the readback polynomial and a rerun after zeroize
// ==========================================================
`timescale 1ns/1ns

module sib_tb
  import sib_pkg::*;
;

  localparam int TAU = 39;

  logic                       clk;
  logic                       rst_b;
  logic                       zeroize_i;
  logic                       data_valid_i;
  logic [3:0][7:0]            data_i;
  logic                       data_hold_o;
  logic                       sib_done_o;
  logic                       rd_en_i;
  logic [7:0]                 rd_idx_i;
  logic [MLDSA_Q_W-1:0]       rd_data_o;

  logic [31:0]                beats[$];
  logic [MLDSA_Q_W-1:0]       exp_coeff[256];
  logic [31:0]                lcg_state;
  int                         cycle_count;
  int                         run_start;
  int                         timeout_limit;
  int                         consumed_beats;

  sib_top #(
    .SIB_TAU (TAU)
  ) dut (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .data_valid_i (data_valid_i),
    .data_i       (data_i),
    .data_hold_o  (data_hold_o),
    .sib_done_o   (sib_done_o),
    .rd_en_i      (rd_en_i),
    .rd_idx_i     (rd_idx_i),
    .rd_data_o    (rd_data_o)
  );

  always #5 clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_coeff(input string name, input logic [MLDSA_Q_W-1:0] expected,
                             input logic [MLDSA_Q_W-1:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("mismatch %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("mismatch %s expected %0b actual %0b", name, expected, actual));
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      report_failure($sformatf("mismatch %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  // Watchdog per run
  always @(posedge clk) begin
    cycle_count++;
    if (timeout_limit > 0 && (cycle_count - run_start) > timeout_limit) begin
      report_failure("timeout: the run took longer than the cycle limit");
    end
  end

  // Beats taken by the DUT while the run is still going
  always @(posedge clk) begin
    if (rst_b && data_valid_i && !data_hold_o && !sib_done_o) begin
      consumed_beats++;
    end
  end

  // Gap length 0 to 3 from the upper LCG bits
  function automatic logic [1:0] next_gap();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[17:16];
  endfunction

  task automatic load_testdata();
    int          fd;
    int          code;
    int          idx;
    int          sgn;
    logic [31:0] word;
    string       line;
    for (int k = 0; k < 256; k++) begin
      exp_coeff[k] = '0;
    end
    fd = $fopen("test/sib_testdata.txt", "r");
    if (fd == 0) begin
      report_failure("could not open the test data file");
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code != 0) begin
        if ($sscanf(line, "B %h", word) == 1) begin
          beats.push_back(word);
        end else if ($sscanf(line, "E %d %d", idx, sgn) == 2) begin
          exp_coeff[idx] = (sgn != 0) ? (MLDSA_Q - 23'd1) : 23'd1;
        end
      end
    end
    $fclose(fd);
    if (beats.size() == 0) begin
      report_failure("test data file holds no stream beats");
    end
  endtask

  // Beat stays on the bus until a cycle with hold low
  task automatic stream_beats();
    logic [1:0] gap;
    logic       taken;
    foreach (beats[b]) begin
      gap = next_gap();
      repeat (gap) begin
        @(negedge clk);
        data_valid_i = 1'b0;
      end
      @(negedge clk);
      data_valid_i = 1'b1;
      data_i       = beats[b];
      taken        = 1'b0;
      while (!taken) begin
        #1;
        check_bit("done_during_stream", 1'b0, sib_done_o);
        if (!data_hold_o) begin
          taken = 1'b1;
        end else begin
          @(negedge clk);
        end
      end
    end
    @(negedge clk);
    data_valid_i = 1'b0;
    data_i       = '0;
  endtask

  task automatic readback_check(input logic expect_zero);
    int                   nonzero;
    logic [MLDSA_Q_W-1:0] expected;
    nonzero = 0;
    for (int k = 0; k <= 256; k++) begin
      @(negedge clk);
      if (k > 0) begin
        expected = expect_zero ? '0 : exp_coeff[k-1];
        check_coeff($sformatf("coeff[%0d]", k - 1), expected, rd_data_o);
        if (rd_data_o != '0) nonzero++;
      end
      if (k < 256) begin
        rd_en_i  = 1'b1;
        rd_idx_i = 8'(k);
      end else begin
        rd_en_i  = 1'b0;
      end
    end
    check_count("nonzero_count", expect_zero ? 0 : TAU, nonzero);
  endtask

  task automatic run_stream();
    run_start      = cycle_count;
    consumed_beats = 0;
    stream_beats();
    while (!sib_done_o) begin
      @(negedge clk);
    end
    check_count("beats_consumed", beats.size(), consumed_beats);
    repeat (20) begin
      @(negedge clk);
      check_bit("done_held", 1'b1, sib_done_o);
      check_bit("hold_after_done", 1'b0, data_hold_o);
    end
    readback_check(1'b0);
  endtask

  initial begin
    clk            = 1'b0;
    rst_b          = 1'b0;
    zeroize_i      = 1'b0;
    data_valid_i   = 1'b0;
    data_i         = '0;
    rd_en_i        = 1'b0;
    rd_idx_i       = '0;
    lcg_state      = 32'd39;
    cycle_count    = 0;
    run_start      = 0;
    timeout_limit  = 0;
    consumed_beats = 0;

    load_testdata();
    timeout_limit = beats.size() * 4 + TAU * 8 + 256 * 2 + 200;

    repeat (10) @(negedge clk);
    rst_b = 1'b1;

    run_stream();

    // Zeroize clears done and the whole polynomial
    @(negedge clk);
    run_start = cycle_count;
    zeroize_i = 1'b1;
    @(negedge clk);
    zeroize_i = 1'b0;
    check_bit("done_after_zeroize", 1'b0, sib_done_o);
    check_bit("hold_after_zeroize", 1'b0, data_hold_o);
    readback_check(1'b1);

    run_stream();

    $display(">>> PASS");
    $finish;
  end

endmodule

//--- source/sib_top.sv
// ==========================================================
// SampleInBall subsystem
// Builds the challenge polynomial c from a byte stream
// ==========================================================
`timescale 1ns/1ns

module sib_top
  import sib_pkg::*;
#(
  parameter int SIB_NUM_SAMPLERS = 4,
  parameter int SIB_SAMPLE_W     = 8,
  parameter int SIB_TAU          = 39,
  parameter int SIB_NUM_COEFF    = 256
) (
  input  logic                                          clk,
  input  logic                                          rst_b,
  input  logic                                          zeroize_i,
  input  logic                                          data_valid_i,
  input  logic [SIB_NUM_SAMPLERS-1:0][SIB_SAMPLE_W-1:0] data_i,
  output logic                                          data_hold_o,
  output logic                                          sib_done_o,
  input  logic                                          rd_en_i,
  input  logic [7:0]                                    rd_idx_i,
  output logic [MLDSA_Q_W-1:0]                          rd_data_o
);

  // Controller to shuffler
  logic       shf_valid;
  logic       shf_hold;
  logic [7:0] shf_index_i;
  logic [7:0] shf_index_j;
  logic       shf_sign;

  // Shuffler to memory
  logic [1:0]                          mem_cs;
  logic [1:0]                          mem_we;
  logic [SIB_MEM_ADDR_W-1:0]           mem_addr0;
  logic [SIB_MEM_ADDR_W-1:0]           mem_addr1;
  logic [SIB_LANES-1:0][MLDSA_Q_W-1:0] mem_wrdata0;
  logic [SIB_LANES-1:0][MLDSA_Q_W-1:0] mem_wrdata1;
  logic [SIB_LANES-1:0][MLDSA_Q_W-1:0] mem_rddata0;
  logic [SIB_LANES-1:0][MLDSA_Q_W-1:0] mem_rddata1;

  sample_in_ball_ctrl #(
    .SIB_NUM_SAMPLERS (SIB_NUM_SAMPLERS),
    .SIB_SAMPLE_W     (SIB_SAMPLE_W),
    .SIB_TAU          (SIB_TAU),
    .SIB_NUM_COEFF    (SIB_NUM_COEFF)
  ) u_ctrl (
    .clk           (clk),
    .rst_b         (rst_b),
    .zeroize_i     (zeroize_i),
    .data_valid_i  (data_valid_i),
    .data_i        (data_i),
    .data_hold_o   (data_hold_o),
    .sib_done_o    (sib_done_o),
    .shf_valid_o   (shf_valid),
    .shf_index_i_o (shf_index_i),
    .shf_index_j_o (shf_index_j),
    .shf_sign_o    (shf_sign),
    .shf_hold_i    (shf_hold)
  );

  sample_in_ball_shuffler u_shuffler (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (zeroize_i),
    .valid_i   (shf_valid),
    .index_i_i (shf_index_i),
    .index_j_i (shf_index_j),
    .sign_i    (shf_sign),
    .hold_o    (shf_hold),
    .cs_o      (mem_cs),
    .we_o      (mem_we),
    .addr0_o   (mem_addr0),
    .addr1_o   (mem_addr1),
    .wrdata0_o (mem_wrdata0),
    .wrdata1_o (mem_wrdata1),
    .rddata0_i (mem_rddata0),
    .rddata1_i (mem_rddata1)
  );

  sib_coeff_mem u_mem (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (zeroize_i),
    .cs_i      (mem_cs),
    .we_i      (mem_we),
    .addr0_i   (mem_addr0),
    .addr1_i   (mem_addr1),
    .wrdata0_i (mem_wrdata0),
    .wrdata1_i (mem_wrdata1),
    .rddata0_o (mem_rddata0),
    .rddata1_o (mem_rddata1),
    .rd_en_i   (rd_en_i),
    .rd_idx_i  (rd_idx_i),
    .rd_data_o (rd_data_o)
  );

endmodule

//--- source/sib_coeff_mem.sv
// ==========================================================
// SampleInBall coefficient memory
// 64 words of 4 coefficients, two read/write ports and a
// single coefficient readback port
// ==========================================================
`timescale 1ns/1ns

module sib_coeff_mem
  import sib_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst_b,
  input  logic                                zeroize_i,

  input  logic [1:0]                          cs_i,
  input  logic [1:0]                          we_i,
  input  logic [SIB_MEM_ADDR_W-1:0]           addr0_i,
  input  logic [SIB_MEM_ADDR_W-1:0]           addr1_i,
  input  logic [SIB_LANES-1:0][MLDSA_Q_W-1:0] wrdata0_i,
  input  logic [SIB_LANES-1:0][MLDSA_Q_W-1:0] wrdata1_i,
  output logic [SIB_LANES-1:0][MLDSA_Q_W-1:0] rddata0_o,
  output logic [SIB_LANES-1:0][MLDSA_Q_W-1:0] rddata1_o,

  input  logic                                rd_en_i,
  input  logic [7:0]                          rd_idx_i,
  output logic [MLDSA_Q_W-1:0]                rd_data_o
);

  localparam int DEPTH = 2 ** SIB_MEM_ADDR_W;

  logic [DEPTH-1:0][SIB_LANES-1:0][MLDSA_Q_W-1:0] mem;

  // Polynomial starts from all zero; port 0 wins on a clash
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      mem <= '0;
    end else if (zeroize_i) begin
      mem <= '0;
    end else begin
      if (cs_i[1] && we_i[1]) mem[addr1_i] <= wrdata1_i;
      if (cs_i[0] && we_i[0]) mem[addr0_i] <= wrdata0_i;
    end
  end

  // Registered reads
  always_ff @(posedge clk) begin
    if (cs_i[0] && !we_i[0]) rddata0_o <= mem[addr0_i];
    if (cs_i[1] && !we_i[1]) rddata1_o <= mem[addr1_i];
  end

  // Readback of a single lane
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_idx_i[7:2]][rd_idx_i[1:0]];
    end
  end

endmodule

//--- source/sample_in_ball_shuffler.sv
// ==========================================================
// SampleInBall shuffler
// Fisher-Yates step as a read phase followed by a write
// phase on the two-port coefficient memory
// ==========================================================
`timescale 1ns/1ns

module sample_in_ball_shuffler
  import sib_pkg::*;
(
  input  logic                                     clk,
  input  logic                                     rst_b,
  input  logic                                     zeroize_i,

  input  logic                                     valid_i,
  input  logic [7:0]                               index_i_i,
  input  logic [7:0]                               index_j_i,
  input  logic                                     sign_i,
  output logic                                     hold_o,

  output logic [1:0]                               cs_o,
  output logic [1:0]                               we_o,
  output logic [SIB_MEM_ADDR_W-1:0]                addr0_o,
  output logic [SIB_MEM_ADDR_W-1:0]                addr1_o,
  output logic [SIB_LANES-1:0][MLDSA_Q_W-1:0]      wrdata0_o,
  output logic [SIB_LANES-1:0][MLDSA_Q_W-1:0]      wrdata1_o,
  input  logic [SIB_LANES-1:0][MLDSA_Q_W-1:0]      rddata0_i,
  input  logic [SIB_LANES-1:0][MLDSA_Q_W-1:0]      rddata1_i
);

  sib_shf_state_e shf_ps;

  logic                 accept;
  logic                 wr_phase;
  logic                 same_word;
  logic [7:0]           index_i_q;
  logic [7:0]           index_j_q;
  logic                 sign_q;
  logic [MLDSA_Q_W-1:0] signed_one;
  logic [MLDSA_Q_W-1:0] coeff_j;

  assign wr_phase = (shf_ps == SHF_WRITE);
  assign accept   = valid_i && !wr_phase;
  assign hold_o   = wr_phase;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      shf_ps <= SHF_IDLE;
    end else if (zeroize_i) begin
      shf_ps <= SHF_IDLE;
    end else if (accept) begin
      shf_ps <= SHF_WRITE;
    end else begin
      shf_ps <= SHF_IDLE;
    end
  end

  // Step operands, held for the write phase
  always_ff @(posedge clk) begin
    if (accept) begin
      index_i_q <= index_i_i;
      index_j_q <= index_j_i;
      sign_q    <= sign_i;
    end
  end

  assign same_word = (index_i_q[7:2] == index_j_q[7:2]);

  // Port 0 carries word(j), port 1 word(i)
  always_comb begin
    cs_o    = 2'b00;
    we_o    = 2'b00;
    addr0_o = index_j_i[7:2];
    addr1_o = index_i_i[7:2];
    if (wr_phase) begin
      addr0_o = index_j_q[7:2];
      addr1_o = index_i_q[7:2];
      cs_o    = same_word ? 2'b01 : 2'b11;
      we_o    = same_word ? 2'b01 : 2'b11;
    end else if (accept) begin
      cs_o = 2'b11;
    end
  end

  // Sign bit 1 maps to -1 mod q
  assign signed_one = sign_q ? (MLDSA_Q - 23'd1) : 23'd1;
  assign coeff_j    = rddata0_i[index_j_q[1:0]];

  // c[i] <= c[j] first, then c[j] <= +/-1
  always_comb begin
    wrdata0_o = rddata0_i;
    wrdata1_o = rddata1_i;
    wrdata1_o[index_i_q[1:0]] = coeff_j;
    if (same_word) begin
      wrdata0_o[index_i_q[1:0]] = coeff_j;
    end
    wrdata0_o[index_j_q[1:0]] = signed_one;
  end

endmodule

//--- source/sample_in_ball_ctrl.sv
// ==========================================================
// SampleInBall controller
// Sign buffer fill, rejection sampling of streamed bytes
// and stall generation towards the byte source
// ==========================================================
`timescale 1ns/1ns

module sample_in_ball_ctrl
  import sib_pkg::*;
#(
  parameter int SIB_NUM_SAMPLERS = 4,
  parameter int SIB_SAMPLE_W     = 8,
  parameter int SIB_TAU          = 39,
  parameter int SIB_NUM_COEFF    = 256
) (
  input  logic                                          clk,
  input  logic                                          rst_b,
  input  logic                                          zeroize_i,

  input  logic                                          data_valid_i,
  input  logic [SIB_NUM_SAMPLERS-1:0][SIB_SAMPLE_W-1:0] data_i,
  output logic                                          data_hold_o,
  output logic                                          sib_done_o,

  output logic                                          shf_valid_o,
  output logic [7:0]                                    shf_index_i_o,
  output logic [7:0]                                    shf_index_j_o,
  output logic                                          shf_sign_o,
  input  logic                                          shf_hold_i
);

  localparam int DATA_W = SIB_NUM_SAMPLERS * SIB_SAMPLE_W;
  localparam int SIGN_W = 2 * DATA_W;
  localparam int SEL_W  = $clog2(SIB_NUM_SAMPLERS);

  localparam logic [7:0] REJ_START = 8'(SIB_NUM_COEFF - SIB_TAU);
  localparam logic [7:0] REJ_LAST  = 8'(SIB_NUM_COEFF - 1);

  sib_fsm_state_e fsm_ps;
  sib_fsm_state_e fsm_ns;

  logic [SIGN_W-1:0]           sign_buffer;
  logic [SIGN_W-1:0]           sign_buffer_nxt;
  logic                        sign_buffer_en;
  logic                        sign_buffer_ph;

  logic [7:0]                  rej_value;
  logic                        rej_value_en;
  logic                        last_sample;

  logic [SIB_NUM_SAMPLERS-1:0] sampler_mask;
  logic [SIB_NUM_SAMPLERS-1:0] sampler_mask_d;
  logic [SIB_NUM_SAMPLERS-1:0] sampler_valid;
  logic                        sampler_mask_en;
  logic                        sampler_hold;
  logic                        index_found;
  logic [SEL_W-1:0]            valid_index;

  // Next state
  always_comb begin
    fsm_ns = fsm_ps;
    unique case (fsm_ps)
      SIB_IDLE: begin
        if (data_valid_i) fsm_ns = SIB_SIGN_BUFFER;
      end
      SIB_SIGN_BUFFER: begin
        if (data_valid_i) fsm_ns = SIB_ACTIVE;
      end
      SIB_ACTIVE: begin
        if (last_sample) fsm_ns = SIB_DONE;
      end
      SIB_DONE: begin
        fsm_ns = SIB_DONE;
      end
    endcase
  end

  // State decoded controls
  always_comb begin
    data_hold_o     = 1'b0;
    sib_done_o      = 1'b0;
    shf_valid_o     = 1'b0;
    sign_buffer_en  = 1'b0;
    sign_buffer_ph  = 1'b0;
    rej_value_en    = 1'b0;
    sampler_mask_en = 1'b0;
    unique case (fsm_ps)
      SIB_IDLE: begin
        sign_buffer_en = data_valid_i;
      end
      SIB_SIGN_BUFFER: begin
        sign_buffer_en = data_valid_i;
        sign_buffer_ph = 1'b1;
      end
      SIB_ACTIVE: begin
        data_hold_o     = sampler_hold | shf_hold_i;
        shf_valid_o     = index_found;
        rej_value_en    = index_found & ~shf_hold_i;
        sampler_mask_en = index_found & sampler_hold & ~shf_hold_i;
      end
      SIB_DONE: begin
        sib_done_o = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      fsm_ps <= SIB_IDLE;
    end else if (zeroize_i) begin
      fsm_ps <= SIB_IDLE;
    end else begin
      fsm_ps <= fsm_ns;
    end
  end

  // First beat fills the low half, second beat the high half
  always_comb begin
    if (sign_buffer_ph) begin
      sign_buffer_nxt = {data_i, {DATA_W{1'b0}}};
    end else begin
      sign_buffer_nxt = {{DATA_W{1'b0}}, data_i};
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      sign_buffer <= '0;
    end else if (zeroize_i || sib_done_o) begin
      sign_buffer <= '0;
    end else if (sign_buffer_en) begin
      sign_buffer <= sign_buffer | sign_buffer_nxt;
    end else if (rej_value_en) begin
      sign_buffer <= sign_buffer >> 1;
    end
  end

  // Rejection bound i, counts from 256-TAU up to 255
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rej_value <= REJ_START;
    end else if (zeroize_i || sib_done_o) begin
      rej_value <= REJ_START;
    end else if (rej_value_en) begin
      rej_value <= rej_value + 8'd1;
    end
  end

  // Per byte compare j <= i on the bytes not yet used
  always_comb begin
    for (int k = 0; k < SIB_NUM_SAMPLERS; k++) begin
      sampler_valid[k] = sampler_mask[k] && (data_i[k] <= rej_value);
    end
  end

  // Lowest passing byte, everything up to it gets masked
  always_comb begin
    index_found    = 1'b0;
    valid_index    = '0;
    sampler_mask_d = sampler_mask;
    for (int k = 0; k < SIB_NUM_SAMPLERS; k++) begin
      if (data_valid_i && !index_found) begin
        sampler_mask_d[k] = 1'b0;
        if (sampler_valid[k]) begin
          index_found = 1'b1;
          valid_index = SEL_W'(k);
        end
      end
    end
  end

  // Mask returns to full once the beat leaves
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      sampler_mask <= '1;
    end else if (zeroize_i || !data_hold_o) begin
      sampler_mask <= '1;
    end else if (sampler_mask_en) begin
      sampler_mask <= sampler_mask_d;
    end
  end

  // More bytes remain after the one picked
  assign sampler_hold = index_found && (valid_index != SEL_W'(SIB_NUM_SAMPLERS - 1));
  assign last_sample  = (rej_value == REJ_LAST) && index_found && !shf_hold_i;

  assign shf_index_i_o = rej_value;
  assign shf_index_j_o = data_i[valid_index];
  assign shf_sign_o    = sign_buffer[0];

endmodule

//--- source/sib_pkg.sv
// ==========================================================
// SampleInBall shared definitions
// Modulus, memory geometry and FSM state encodings
// ==========================================================

package sib_pkg;

  // ML-DSA modulus and coefficient width
  localparam logic [22:0] MLDSA_Q   = 23'd8380417;
  localparam int          MLDSA_Q_W = 23;

  // Coefficient memory geometry
  // Index bits [7:2] pick the word, [1:0] the lane
  localparam int SIB_MEM_ADDR_W = 6;
  localparam int SIB_LANES      = 4;

  // Controller sequencing
  typedef enum logic [1:0] {
    SIB_IDLE        = 2'd0,
    SIB_SIGN_BUFFER = 2'd1,
    SIB_ACTIVE      = 2'd2,
    SIB_DONE        = 2'd3
  } sib_fsm_state_e;

  // Shuffler phase, read is issued from SHF_IDLE
  typedef enum logic {
    SHF_IDLE  = 1'b0,
    SHF_WRITE = 1'b1
  } sib_shf_state_e;

endpackage
